/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := cache_tb
FILELIST := project.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* block_bus_arbiter.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module block_bus_arbiter
    import cache_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  bus_req_t i_instr_req,
    input  bus_req_t i_data_req,
    input  logic     i_done,
    output logic     o_instr_done,
    output logic     o_data_done,
    output logic     o_start_read,
    output logic     o_start_write,
    output addr_t    o_bus_addr,
    output block_t   o_block_write
);

    arb_state_e state_q;
    addr_t      addr_q;
    block_t     block_q;

    logic     data_wants;
    logic     instr_wants;
    bus_req_t sel_req;

    // -------------------------------------------------------------------
    // Request selection.
    // -------------------------------------------------------------------
    assign data_wants  = i_data_req.rd | i_data_req.wr;
    assign instr_wants = i_instr_req.rd | i_instr_req.wr;

    // Data side wins a tie.
    assign sel_req = data_wants ? i_data_req : i_instr_req;

    // -------------------------------------------------------------------
    // Grant FSM.
    // -------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q       <= ARB_IDLE;
            o_start_read  <= 1'b0;
            o_start_write <= 1'b0;
        end else begin
            o_start_read  <= 1'b0;
            o_start_write <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    if (data_wants || instr_wants) begin
                        state_q       <= data_wants ? ARB_DATA : ARB_INSTR;
                        o_start_write <= sel_req.wr;
                        o_start_read  <= sel_req.rd;
                    end
                end
                ARB_INSTR, ARB_DATA: begin
                    // Owner keeps the port until the transfer completes.
                    if (i_done) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Address and block captured at grant.
    always_ff @(posedge i_clk) begin
        if ((state_q == ARB_IDLE) && (data_wants || instr_wants)) begin
            addr_q  <= sel_req.addr;
            block_q <= sel_req.wblock;
        end
    end

    assign o_bus_addr    = (state_q != ARB_IDLE) ? addr_q : '0;
    assign o_block_write = (state_q != ARB_IDLE) ? block_q : '0;

    // Done goes back to the owner only.
    assign o_instr_done = i_done && (state_q == ARB_INSTR);
    assign o_data_done  = i_done && (state_q == ARB_DATA);

endmodule

/* cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Address and data widths.
`define CACHE_ADDR_W      64
`define CACHE_DWORD_W     64
`define CACHE_INSTR_W     32

// Line width and cache geometry.
`define CACHE_BLOCK_W     512
`define CACHE_LINES       8
`define CACHE_INDEX_W     3
`define CACHE_OFFSET_W    6

// Tag is what remains above index and offset.
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// Word selects within one line.
`define CACHE_DWORD_SEL_W 3
`define CACHE_INSTR_SEL_W 4

// Bytes in one data word.
`define CACHE_DWORD_BYTES 8

`endif

/* cache_pkg.sv */
package cache_pkg;

`include "cache_defs.svh"

    // Basic data types.
    typedef logic [`CACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`CACHE_DWORD_W-1:0] dword_t;
    typedef logic [`CACHE_INSTR_W-1:0] instr_t;
    typedef logic [`CACHE_BLOCK_W-1:0] block_t;

    // Access size, same coding as funct3[1:0].
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'b00,
        SIZE_HALF   = 2'b01,
        SIZE_WORD   = 2'b10,
        SIZE_DOUBLE = 2'b11
    } store_size_e;

    // Load/store request from the core side.
    typedef struct packed {
        logic        rd;
        logic        wr;
        addr_t       addr;
        dword_t      wdata;
        store_size_e size;
    } data_req_t;

    // Claim of one cache on the external block port.
    typedef struct packed {
        logic   rd;
        logic   wr;
        addr_t  addr;
        block_t wblock;
    } bus_req_t;

    // Cache controller states.
    typedef enum logic [1:0] {
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL
    } cache_state_e;

    // Arbiter states.
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INSTR,
        ARB_DATA
    } arb_state_e;

endpackage

/* cache_sva.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module cache_sva
    import cache_pkg::*;
(
    input logic  i_clk,
    input logic  i_arst_n,
    input logic  i_start_read,
    input logic  i_start_write,
    input addr_t i_bus_addr,
    input logic  i_done,
    input logic  i_instr_hit,
    input logic  i_data_hit
);

    logic start;
    logic busy_q;

    assign start = i_start_read | i_start_write;

    // Open transaction from start pulse to done pulse.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if (i_done) begin
            busy_q <= 1'b0;
        end
    end

    // ---------------------------------------------------------------------
    // External port rules.
    // ---------------------------------------------------------------------
    a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_start_read && i_start_write))
        else $error("start read and start write high together");

    a_pulse_width: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        start |=> !start)
        else $error("start strobe longer than one cycle");

    a_block_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_bus_addr[`CACHE_OFFSET_W-1:0] == '0)
        else $error("bus address not block aligned");

    a_no_overlap: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        busy_q |-> !start)
        else $error("start strobe before done of the open transaction");

    // All lines invalid while in reset.
    a_reset_no_hit: assert property (@(posedge i_clk)
        !i_arst_n |-> !(i_instr_hit || i_data_hit))
        else $error("hit output high during reset");

endmodule

/* cache_tb.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module cache_tb
    import cache_pkg::*;
();

    typedef enum logic [1:0] {K_FETCH, K_LOAD, K_STORE, K_BOTH} kind_e;

    typedef struct packed {
        kind_e       kind;
        addr_t       addr;
        store_size_e size;
        dword_t      wdata;
        logic        exp_ma;
        logic        quiet;
    } row_t;

    localparam int     N_ROWS         = 17;
    localparam int     TIMEOUT_CYCLES = N_ROWS * 2 * 8 + 20;
    localparam dword_t IMAGE_KEY      = 64'h5a5a_0000_0000_a5a5;
    localparam addr_t  IDLE_FETCH     = 64'h2;

    // Kind, address, size, store data, misaligned flag, no bus traffic allowed.
    localparam row_t ROWS [N_ROWS] = '{
        '{K_FETCH, 64'h1000, SIZE_WORD,   64'h0,                   1'b0, 1'b0},
        '{K_FETCH, 64'h1024, SIZE_WORD,   64'h0,                   1'b0, 1'b1},
        '{K_FETCH, 64'h103c, SIZE_WORD,   64'h0,                   1'b0, 1'b1},
        '{K_STORE, 64'h200d, SIZE_BYTE,   64'h0000_0000_0000_00c3, 1'b0, 1'b0},
        '{K_STORE, 64'h200e, SIZE_HALF,   64'h0000_0000_0000_b7e1, 1'b0, 1'b1},
        '{K_STORE, 64'h2008, SIZE_WORD,   64'h0000_0000_1357_9bdf, 1'b0, 1'b1},
        '{K_LOAD,  64'h2008, SIZE_DOUBLE, 64'h0,                   1'b0, 1'b1},
        '{K_STORE, 64'h2010, SIZE_DOUBLE, 64'h0123_4567_89ab_cdef, 1'b0, 1'b1},
        '{K_LOAD,  64'h2208, SIZE_DOUBLE, 64'h0,                   1'b0, 1'b0},
        '{K_LOAD,  64'h2008, SIZE_DOUBLE, 64'h0,                   1'b0, 1'b0},
        '{K_LOAD,  64'h2010, SIZE_DOUBLE, 64'h0,                   1'b0, 1'b1},
        '{K_FETCH, 64'h1002, SIZE_WORD,   64'h0,                   1'b1, 1'b1},
        '{K_STORE, 64'h2012, SIZE_WORD,   64'h0000_0000_dead_beef, 1'b1, 1'b1},
        '{K_LOAD,  64'h2010, SIZE_DOUBLE, 64'h0,                   1'b0, 1'b1},
        '{K_BOTH,  64'h3040, SIZE_DOUBLE, 64'h0,                   1'b0, 1'b0},
        '{K_LOAD,  64'h3044, SIZE_DOUBLE, 64'h0,                   1'b1, 1'b1},
        '{K_FETCH, 64'h1004, SIZE_WORD,   64'h0,                   1'b0, 1'b1}
    };

    logic      clk;
    logic      arst_n;
    addr_t     fetch_addr;
    instr_t    instr;
    logic      instr_hit;
    logic      instr_ma;
    data_req_t data_req;
    dword_t    load_data;
    logic      data_hit;
    logic      store_ma;
    logic      start_read;
    logic      start_write;
    addr_t     bus_addr;
    block_t    block_write;
    block_t    block_read;
    logic      done;

    block_t      mem_blocks [addr_t];
    dword_t      shadow [addr_t];
    logic [31:0] lfsr_state;
    logic        txn_open    = 1'b0;
    int          error_count = 0;
    int          start_total = 0;
    int          cycle_count = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;

    tb_clock_gen CLK_GEN (
        .o_clk    ( clk    ),
        .o_arst_n ( arst_n )
    );

    cache_top DUT (
        .i_clk           ( clk         ),
        .i_arst_n        ( arst_n      ),
        .i_fetch_addr    ( fetch_addr  ),
        .o_instr         ( instr       ),
        .o_instr_hit     ( instr_hit   ),
        .o_instr_addr_ma ( instr_ma    ),
        .i_data_req      ( data_req    ),
        .o_load_data     ( load_data   ),
        .o_data_hit      ( data_hit    ),
        .o_store_addr_ma ( store_ma    ),
        .o_start_read    ( start_read  ),
        .o_start_write   ( start_write ),
        .o_bus_addr      ( bus_addr    ),
        .o_block_write   ( block_write ),
        .i_block_read    ( block_read  ),
        .i_done          ( done        )
    );

    bind cache_top cache_sva SVA (
        .i_clk         ( i_clk         ),
        .i_arst_n      ( i_arst_n      ),
        .i_start_read  ( o_start_read  ),
        .i_start_write ( o_start_write ),
        .i_bus_addr    ( o_bus_addr    ),
        .i_done        ( i_done        ),
        .i_instr_hit   ( o_instr_hit   ),
        .i_data_hit    ( o_data_hit    )
    );

    // ---------------------------------------------------------------------
    // Reference model: memory image, shadow stores, LFSR.
    // ---------------------------------------------------------------------
    function automatic dword_t image_dword(input addr_t a);
        return {a[`CACHE_ADDR_W-1:3], 3'b000} ^ IMAGE_KEY;
    endfunction

    function automatic addr_t block_of(input addr_t a);
        return {a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic block_t memory_block(input addr_t blk);
        block_t b;
        if (mem_blocks.exists(blk) != 0) begin
            b = mem_blocks[blk];
        end else begin
            for (int j = 0; j < 8; j++) begin
                b[j*64 +: 64] = image_dword(blk + addr_t'(8 * j));
            end
        end
        return b;
    endfunction

    function automatic dword_t expected_dword(input addr_t a);
        addr_t key;
        key = {a[`CACHE_ADDR_W-1:3], 3'b000};
        return (shadow.exists(key) != 0) ? shadow[key] : image_dword(key);
    endfunction

    // Code fetches stay away from stored lines, so the image rule holds.
    function automatic instr_t expected_instr(input addr_t a);
        dword_t d;
        d = image_dword(a);
        return a[2] ? d[63:32] : d[31:0];
    endfunction

    // Little-endian byte lanes, 1 << size bytes from the address offset.
    task automatic apply_store(input addr_t a, input store_size_e size, input dword_t wdata);
        dword_t d;
        int     nbytes;
        d      = expected_dword(a);
        nbytes = 1 << int'(size);
        for (int b = 0; b < nbytes; b++) begin
            d[(int'(a[2:0]) + b) * 8 +: 8] = wdata[b*8 +: 8];
        end
        shadow[{a[`CACHE_ADDR_W-1:3], 3'b000}] = d;
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ---------------------------------------------------------------------
    // Compare tasks.
    // ---------------------------------------------------------------------
    task automatic check_instr(input instr_t got, input instr_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_dword(input dword_t got, input dword_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%-36s ok", name);
        end else begin
            fail_count++;
            $display("%-36s FAILED", name);
        end
    endtask

    function automatic logic row_complete(input kind_e kind);
        logic fetch_ok;
        logic data_ok;
        fetch_ok = instr_hit || instr_ma;
        data_ok  = data_hit || store_ma;
        if (kind == K_FETCH) begin
            return fetch_ok;
        end
        return (kind == K_BOTH) ? (fetch_ok && data_ok) : data_ok;
    endfunction

    task automatic check_row(input row_t row);
        if ((row.kind == K_FETCH) || (row.kind == K_BOTH)) begin
            check_flag(instr_ma, row.exp_ma, "fetch misaligned flag");
            if (!row.exp_ma) begin
                check_instr(instr, expected_instr(row.addr), "fetched word");
            end
        end
        if (row.kind != K_FETCH) begin
            check_flag(store_ma, row.exp_ma, "data misaligned flag");
            if (!row.exp_ma && (row.kind == K_STORE)) begin
                apply_store(row.addr, row.size, row.wdata);
            end else if (!row.exp_ma) begin
                check_dword(load_data, expected_dword(row.addr), "load data");
            end
        end
    endtask

    // ---------------------------------------------------------------------
    // Stimulus.
    // ---------------------------------------------------------------------
    initial begin : run_tests
        row_t   row;
        int     errors_before;
        int     starts_before;
        block_t blk;
        fetch_addr    = 64'h1000;
        data_req      = '0;
        data_req.rd   = 1'b1;
        data_req.addr = 64'h2000;
        data_req.size = SIZE_DOUBLE;
        // Aligned requests in reset see only invalid lines.
        repeat (4) @(negedge clk);
        check_flag(instr_hit | data_hit, 1'b0, "hit output during reset");
        @(posedge clk);
        #2;
        fetch_addr = IDLE_FETCH;
        data_req   = '0;
        @(posedge arst_n);
        repeat (4) @(negedge clk);
        check_flag(start_total != 0, 1'b0, "start strobe with no request");
        report_test("reset state", 0);
        @(posedge clk);
        #2;
        for (int i = 0; i < N_ROWS; i++) begin
            row           = ROWS[i];
            errors_before = error_count;
            starts_before = start_total;
            if ((row.kind == K_FETCH) || (row.kind == K_BOTH)) begin
                fetch_addr = row.addr;
            end
            if (row.kind != K_FETCH) begin
                data_req.rd    = (row.kind != K_STORE);
                data_req.wr    = (row.kind == K_STORE);
                data_req.addr  = row.addr;
                data_req.wdata = row.wdata;
                data_req.size  = row.size;
            end
            @(negedge clk);
            while (!row_complete(row.kind)) begin
                @(negedge clk);
            end
            check_row(row);
            if (row.quiet) begin
                check_flag(start_total != starts_before, 1'b0, "bus traffic on this access");
            end
            report_test($sformatf("row %0d %s %h", i, row.kind.name(), row.addr), errors_before);
            @(posedge clk);
            #2;
            fetch_addr = IDLE_FETCH;
            data_req   = '0;
        end

        // Evicted dwords must sit in the memory model.
        errors_before = error_count;
        check_flag(mem_blocks.exists(64'h2000) != 0, 1'b1, "dirty line written back");
        foreach (shadow[a]) begin
            if (mem_blocks.exists(block_of(a)) != 0) begin
                blk = mem_blocks[block_of(a)];
                check_dword(blk[a[5:3]*64 +: 64], shadow[a], "written-back dword");
            end
        end
        report_test("writeback in memory model", errors_before);

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 pass_count + fail_count, pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // ---------------------------------------------------------------------
    // External memory and port monitor.
    // ---------------------------------------------------------------------
    initial begin : memory_model
        addr_t req_addr;
        int    delay;
        done       = 1'b0;
        block_read = '0;
        lfsr_state = 32'h87a8;
        forever begin
            @(negedge clk);
            if (start_read || start_write) begin
                req_addr = bus_addr;
                if (start_write) begin
                    mem_blocks[req_addr] = block_write;
                end
                lfsr_state = lfsr_step(lfsr_state);
                delay      = int'(lfsr_state[0]);
                lfsr_state = lfsr_step(lfsr_state);
                delay      = 2 * delay + int'(lfsr_state[0]) + 1;
                repeat (delay) @(posedge clk);
                #2;
                block_read = memory_block(req_addr);
                done       = 1'b1;
                @(posedge clk);
                #2;
                done       = 1'b0;
            end
        end
    end

    always @(negedge clk) begin : port_monitor
        if (done) begin
            txn_open = 1'b0;
        end
        if (start_read || start_write) begin
            start_total++;
            check_flag(start_read && start_write, 1'b0, "both start strobes together");
            check_flag(txn_open, 1'b0, "start strobe during an open transaction");
            txn_open = 1'b1;
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* cache_top.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,

    // Fetch side.
    input  addr_t     i_fetch_addr,
    output instr_t    o_instr,
    output logic      o_instr_hit,
    output logic      o_instr_addr_ma,

    // Load/store side.
    input  data_req_t i_data_req,
    output dword_t    o_load_data,
    output logic      o_data_hit,
    output logic      o_store_addr_ma,

    // External block port.
    output logic      o_start_read,
    output logic      o_start_write,
    output addr_t     o_bus_addr,
    output block_t    o_block_write,
    input  block_t    i_block_read,
    input  logic      i_done
);

    // -------------------------------------------------------------------
    // Internal nets.
    // -------------------------------------------------------------------
    bus_req_t instr_bus_req;
    bus_req_t data_bus_req;
    logic     instr_done;
    logic     data_done;

    // Instruction cache.
    instr_cache I_CACHE (
        .i_clk           ( i_clk           ),
        .i_arst_n        ( i_arst_n        ),
        .i_fetch_addr    ( i_fetch_addr    ),
        .i_block_read    ( i_block_read    ),
        .i_done          ( instr_done      ),
        .o_bus_req       ( instr_bus_req   ),
        .o_instr         ( o_instr         ),
        .o_instr_hit     ( o_instr_hit     ),
        .o_instr_addr_ma ( o_instr_addr_ma )
    );

    // Data cache.
    data_cache D_CACHE (
        .i_clk           ( i_clk           ),
        .i_arst_n        ( i_arst_n        ),
        .i_data_req      ( i_data_req      ),
        .i_block_read    ( i_block_read    ),
        .i_done          ( data_done       ),
        .o_bus_req       ( data_bus_req    ),
        .o_load_data     ( o_load_data     ),
        .o_data_hit      ( o_data_hit      ),
        .o_store_addr_ma ( o_store_addr_ma )
    );

    // Shared port arbiter.
    block_bus_arbiter BUS_ARB (
        .i_clk         ( i_clk         ),
        .i_arst_n      ( i_arst_n      ),
        .i_instr_req   ( instr_bus_req ),
        .i_data_req    ( data_bus_req  ),
        .i_done        ( i_done        ),
        .o_instr_done  ( instr_done    ),
        .o_data_done   ( data_done     ),
        .o_start_read  ( o_start_read  ),
        .o_start_write ( o_start_write ),
        .o_bus_addr    ( o_bus_addr    ),
        .o_block_write ( o_block_write )
    );

endmodule

/* data_cache.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module data_cache
    import cache_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  data_req_t i_data_req,
    input  block_t    i_block_read,
    input  logic      i_done,
    output bus_req_t  o_bus_req,
    output dword_t    o_load_data,
    output logic      o_data_hit,
    output logic      o_store_addr_ma
);

    // -------------------------------------------------------------------
    // Storage.
    // -------------------------------------------------------------------
    logic [`CACHE_TAG_W-1:0] tag_mem  [`CACHE_LINES];
    block_t                  line_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;

    cache_state_e state_q;
    addr_t        miss_addr_q;

    logic [`CACHE_INDEX_W-1:0]     req_index;
    logic [`CACHE_INDEX_W-1:0]     miss_index;
    logic [`CACHE_TAG_W-1:0]       req_tag;
    logic [`CACHE_DWORD_SEL_W-1:0] dword_sel;
    logic [2:0]                    byte_off;
    logic                          access;
    logic                          misaligned;
    logic                          miss;
    logic                          store_hit;
    logic [`CACHE_DWORD_BYTES-1:0] size_mask;
    logic [`CACHE_DWORD_BYTES-1:0] byte_mask;
    dword_t                        shifted_data;
    dword_t                        merged_dword;
    block_t                        store_line;
    addr_t                         victim_addr;
    addr_t                         refill_addr;

    // -------------------------------------------------------------------
    // Address split and alignment.
    // -------------------------------------------------------------------
    assign req_index  = i_data_req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign req_tag    = i_data_req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign dword_sel  = i_data_req.addr[3 +: `CACHE_DWORD_SEL_W];
    assign byte_off   = i_data_req.addr[2:0];
    assign miss_index = miss_addr_q[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    // Alignment and byte lanes follow the access size.
    always_comb begin
        case (i_data_req.size)
            SIZE_BYTE: begin
                misaligned = 1'b0;
                size_mask  = 8'h01;
            end
            SIZE_HALF: begin
                misaligned = byte_off[0];
                size_mask  = 8'h03;
            end
            SIZE_WORD: begin
                misaligned = |byte_off[1:0];
                size_mask  = 8'h0f;
            end
            default: begin
                misaligned = |byte_off;
                size_mask  = 8'hff;
            end
        endcase
    end

    assign access = i_data_req.rd | i_data_req.wr;

    // Raised for any load or store off its size.
    assign o_store_addr_ma = access && misaligned;

    // -------------------------------------------------------------------
    // Lookup and store merge.
    // -------------------------------------------------------------------
    assign o_data_hit = access && !misaligned && valid_q[req_index]
                        && (tag_mem[req_index] == req_tag);

    assign o_load_data = line_mem[req_index][dword_sel*`CACHE_DWORD_W +: `CACHE_DWORD_W];

    assign miss      = access && !misaligned && !o_data_hit;
    assign store_hit = (state_q == ST_LOOKUP) && o_data_hit && i_data_req.wr;

    assign byte_mask    = size_mask << byte_off;
    assign shifted_data = i_data_req.wdata << {byte_off, 3'b000};

    always_comb begin
        for (int b = 0; b < `CACHE_DWORD_BYTES; b++) begin
            merged_dword[b*8 +: 8] = byte_mask[b] ? shifted_data[b*8 +: 8]
                                                  : o_load_data[b*8 +: 8];
        end
        store_line = line_mem[req_index];
        store_line[dword_sel*`CACHE_DWORD_W +: `CACHE_DWORD_W] = merged_dword;
    end

    // -------------------------------------------------------------------
    // Miss control.
    // -------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_LOOKUP;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                ST_LOOKUP: begin
                    if (store_hit) begin
                        dirty_q[req_index] <= 1'b1;
                    end else if (miss) begin
                        // Dirty victim goes out first.
                        if (valid_q[req_index] && dirty_q[req_index]) begin
                            state_q <= ST_WRITEBACK;
                        end else begin
                            state_q <= ST_REFILL;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (i_done) begin
                        state_q <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (i_done) begin
                        state_q             <= ST_LOOKUP;
                        valid_q[miss_index] <= 1'b1;
                        dirty_q[miss_index] <= 1'b0;
                    end
                end
                default: state_q <= ST_LOOKUP;
            endcase
        end
    end

    // Lines, tags and miss address.
    always_ff @(posedge i_clk) begin
        if ((state_q == ST_LOOKUP) && miss) begin
            miss_addr_q <= i_data_req.addr;
        end
        if (store_hit) begin
            line_mem[req_index] <= store_line;
        end
        if ((state_q == ST_REFILL) && i_done) begin
            line_mem[miss_index] <= i_block_read;
            tag_mem[miss_index]  <= miss_addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        end
    end

    // -------------------------------------------------------------------
    // Port request.
    // -------------------------------------------------------------------
    assign victim_addr = {tag_mem[miss_index], miss_index, {`CACHE_OFFSET_W{1'b0}}};
    assign refill_addr = {miss_addr_q[`CACHE_ADDR_W-1:`CACHE_OFFSET_W],
                          {`CACHE_OFFSET_W{1'b0}}};

    always_comb begin
        o_bus_req        = '0;
        o_bus_req.wr     = (state_q == ST_WRITEBACK);
        o_bus_req.rd     = (state_q == ST_REFILL);
        o_bus_req.addr   = (state_q == ST_WRITEBACK) ? victim_addr : refill_addr;
        o_bus_req.wblock = line_mem[miss_index];
    end

endmodule

/* instr_cache.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module instr_cache
    import cache_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  addr_t    i_fetch_addr,
    input  block_t   i_block_read,
    input  logic     i_done,
    output bus_req_t o_bus_req,
    output instr_t   o_instr,
    output logic     o_instr_hit,
    output logic     o_instr_addr_ma
);

    // -------------------------------------------------------------------
    // Storage.
    // -------------------------------------------------------------------
    logic [`CACHE_TAG_W-1:0] tag_mem  [`CACHE_LINES];
    block_t                  line_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;

    cache_state_e state_q;
    addr_t        miss_addr_q;

    logic [`CACHE_INDEX_W-1:0]     req_index;
    logic [`CACHE_INDEX_W-1:0]     miss_index;
    logic [`CACHE_TAG_W-1:0]       req_tag;
    logic [`CACHE_INSTR_SEL_W-1:0] word_sel;
    logic                          miss;

    // -------------------------------------------------------------------
    // Lookup.
    // -------------------------------------------------------------------
    assign req_index  = i_fetch_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign req_tag    = i_fetch_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign word_sel   = i_fetch_addr[2 +: `CACHE_INSTR_SEL_W];
    assign miss_index = miss_addr_q[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    // Every aligned fetch address counts as a request.
    assign o_instr_addr_ma = |i_fetch_addr[1:0];

    assign o_instr_hit = valid_q[req_index] && (tag_mem[req_index] == req_tag)
                         && !o_instr_addr_ma;

    assign o_instr = line_mem[req_index][word_sel*`CACHE_INSTR_W +: `CACHE_INSTR_W];

    assign miss = !o_instr_addr_ma && !o_instr_hit;

    // -------------------------------------------------------------------
    // Refill control.
    // -------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_LOOKUP;
            valid_q <= '0;
        end else begin
            case (state_q)
                ST_LOOKUP: begin
                    if (miss) begin
                        state_q <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (i_done) begin
                        state_q             <= ST_LOOKUP;
                        valid_q[miss_index] <= 1'b1;
                    end
                end
                default: state_q <= ST_LOOKUP;
            endcase
        end
    end

    // Line, tag and miss address.
    always_ff @(posedge i_clk) begin
        if ((state_q == ST_LOOKUP) && miss) begin
            miss_addr_q <= i_fetch_addr;
        end
        if ((state_q == ST_REFILL) && i_done) begin
            line_mem[miss_index] <= i_block_read;
            tag_mem[miss_index]  <= miss_addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        end
    end

    // Read request held for the whole refill.
    always_comb begin
        o_bus_req      = '0;
        o_bus_req.rd   = (state_q == ST_REFILL);
        o_bus_req.addr = {miss_addr_q[`CACHE_ADDR_W-1:`CACHE_OFFSET_W],
                          {`CACHE_OFFSET_W{1'b0}}};
    end

endmodule

/* project.f */
+incdir+.
cache_pkg.sv
instr_cache.sv
data_cache.sv
block_bus_arbiter.sv
cache_top.sv
tb_clock_gen.sv
cache_sva.sv
cache_tb.sv

/* tb_clock_gen.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module tb_clock_gen (
    output logic o_clk,
    output logic o_arst_n
);

    // 20 ns period.
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // Reset held for 8 cycles, released just after an edge.
    initial begin
        o_arst_n = 1'b0;
        repeat (8) @(posedge o_clk);
        #2;
        o_arst_n = 1'b1;
    end

endmodule
